// File: verilog/video_pkg.sv
// Video subsystem shared types
package video_pkg;

    // Helper widths
    localparam int MAP_AW = 6;
    localparam int PAL_AW = 8;
    localparam int POS_W  = 6;
    localparam int COL_W  = 12;

    // CPU address map, 12-bit word addresses
    localparam logic [11:0] MAP0_BASE   = 12'h000;
    localparam logic [11:0] MAP1_BASE   = 12'h040;
    localparam logic [11:0] PAL_BASE    = 12'h100;
    localparam logic [11:0] SCROLL_BASE = 12'h200;
    localparam logic [11:0] PRIO_ADDR   = 12'h204;

    typedef struct packed {
        logic [11:0] addr;
        logic [15:0] data;
    } cpu_req_t;

    typedef struct packed {
        logic              en;
        logic [MAP_AW-1:0] index;
        logic [7:0]        entry;
    } map_wr_t;

    // Colour is 4 bits each of red, green, blue
    typedef struct packed {
        logic              en;
        logic [PAL_AW-1:0] index;
        logic [COL_W-1:0]  colour;
    } pal_wr_t;

    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
    } scroll_t;

    // Color 0 is transparent
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] color;
    } layer_pxl_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [POS_W-1:0] hdump;
        logic [POS_W-1:0] vdump;
        logic             lhbl;
        logic             lvbl;
    } raster_t;

endpackage

// File: verilog/video_timing.sv
// Raster timing generator
`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL  = 64,
    parameter int H_ACTIVE = 48,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input  logic                clk,
    input  logic                arst_n,
    output logic                pxl_cen,
    output video_pkg::raster_t  raster,
    output logic                hs,
    output logic                vs
);

    logic [video_pkg::POS_W-1:0] h_next;
    logic [video_pkg::POS_W-1:0] v_next;
    logic                        h_wrap;

    // Position of the next pixel
    always_comb begin
        h_wrap = raster.hdump == video_pkg::POS_W'(H_TOTAL - 1);
        h_next = h_wrap ? '0 : raster.hdump + 1'b1;
        if (!h_wrap) begin
            v_next = raster.vdump;
        end else if (raster.vdump == video_pkg::POS_W'(V_TOTAL - 1)) begin
            v_next = '0;
        end else begin
            v_next = raster.vdump + 1'b1;
        end
    end

    // Half rate pixel enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    // Start at the last blank position so the first pixel is (0,0)
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raster.hdump <= video_pkg::POS_W'(H_TOTAL - 1);
            raster.vdump <= video_pkg::POS_W'(V_TOTAL - 1);
            raster.lhbl  <= 1'b0;
            raster.lvbl  <= 1'b0;
            hs           <= 1'b0;
            vs           <= 1'b0;
        end else if (pxl_cen) begin
            raster.hdump <= h_next;
            raster.vdump <= v_next;
            raster.lhbl  <= h_next < H_ACTIVE;
            raster.lvbl  <= v_next < V_ACTIVE;
            hs           <= (h_next >= H_ACTIVE + 4) && (h_next < H_ACTIVE + 8);
            vs           <= (v_next >= V_ACTIVE + 4) && (v_next < V_ACTIVE + 8);
        end
    end

endmodule

// File: verilog/cpu_reg_decode.sv
// CPU write decoder
`timescale 1ns/1ps

module cpu_reg_decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cpu_valid,
    input  video_pkg::cpu_req_t  cpu_req,
    output logic                 cpu_ready,
    input  video_pkg::raster_t   raster,
    output video_pkg::map_wr_t   map0_wr,
    output video_pkg::map_wr_t   map1_wr,
    output video_pkg::pal_wr_t   pal_wr,
    output video_pkg::scroll_t   scroll0,
    output video_pkg::scroll_t   scroll1,
    output logic                 prio
);

    logic map0_hit;
    logic map1_hit;
    logic pal_hit;
    logic scroll_hit;
    logic prio_hit;
    logic accept;

    // Region decode
    always_comb begin
        map0_hit   = cpu_req.addr[11:6] == video_pkg::MAP0_BASE[11:6];
        map1_hit   = cpu_req.addr[11:6] == video_pkg::MAP1_BASE[11:6];
        pal_hit    = cpu_req.addr[11:8] == video_pkg::PAL_BASE[11:8];
        scroll_hit = cpu_req.addr[11:2] == video_pkg::SCROLL_BASE[11:2];
        prio_hit   = cpu_req.addr == video_pkg::PRIO_ADDR;
    end

    // Palette is busy while the display is active
    assign cpu_ready = !(pal_hit && raster.lhbl && raster.lvbl);
    assign accept    = cpu_valid && cpu_ready;

    // One cycle write strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            map0_wr <= '0;
            map1_wr <= '0;
            pal_wr  <= '0;
        end else begin
            map0_wr.en     <= accept && map0_hit;
            map0_wr.index  <= cpu_req.addr[video_pkg::MAP_AW-1:0];
            map0_wr.entry  <= cpu_req.data[7:0];
            map1_wr.en     <= accept && map1_hit;
            map1_wr.index  <= cpu_req.addr[video_pkg::MAP_AW-1:0];
            map1_wr.entry  <= cpu_req.data[7:0];
            pal_wr.en      <= accept && pal_hit;
            pal_wr.index   <= cpu_req.addr[video_pkg::PAL_AW-1:0];
            pal_wr.colour  <= cpu_req.data[video_pkg::COL_W-1:0];
        end
    end

    // Scroll and priority registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scroll0 <= '0;
            scroll1 <= '0;
            prio    <= 1'b0;
        end else if (accept) begin
            if (scroll_hit) begin
                case (cpu_req.addr[1:0])
                    2'd0: scroll0.x <= cpu_req.data[video_pkg::POS_W-1:0];
                    2'd1: scroll0.y <= cpu_req.data[video_pkg::POS_W-1:0];
                    2'd2: scroll1.x <= cpu_req.data[video_pkg::POS_W-1:0];
                    default: scroll1.y <= cpu_req.data[video_pkg::POS_W-1:0];
                endcase
            end
            if (prio_hit) begin
                prio <= cpu_req.data[0];
            end
        end
    end

endmodule

// File: verilog/tile_layer.sv
// Scrolling solid tile layer
`timescale 1ns/1ps

module tile_layer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pxl_cen,
    input  video_pkg::raster_t     raster,
    input  video_pkg::scroll_t     scroll,
    input  video_pkg::map_wr_t     map_wr,
    output video_pkg::layer_pxl_t  pxl
);

    localparam int MAP_DEPTH = 2 ** video_pkg::MAP_AW;

    // 8x8 tiles on a 64x64 wrapping plane
    video_pkg::layer_pxl_t        map_mem [MAP_DEPTH];
    logic [video_pkg::POS_W-1:0]  pos_x;
    logic [video_pkg::POS_W-1:0]  pos_y;
    logic [video_pkg::MAP_AW-1:0] map_idx;

    // Map powers up cleared
    initial begin
        for (int i = 0; i < MAP_DEPTH; i++) begin
            map_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (map_wr.en) begin
            map_mem[map_wr.index] <= map_wr.entry;
        end
    end

    // Sum wraps at 64 through the 6-bit width
    always_comb begin
        pos_x   = raster.hdump + scroll.x;
        pos_y   = raster.vdump + scroll.y;
        map_idx = {pos_y[5:3], pos_x[5:3]};
    end

    // One pixel behind the raster
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= map_mem[map_idx];
        end
    end

endmodule

// File: verilog/color_mixer.sv
// Layer mixer and palette
`timescale 1ns/1ps

module color_mixer (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   pxl_cen,
    input  video_pkg::raster_t     raster,
    input  video_pkg::layer_pxl_t  pxl0,
    input  video_pkg::layer_pxl_t  pxl1,
    input  logic                   prio,
    input  video_pkg::pal_wr_t     pal_wr,
    output video_pkg::rgb_t        rgb,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly
);

    localparam int PAL_DEPTH = 2 ** video_pkg::PAL_AW;

    logic [video_pkg::COL_W-1:0] pal_mem [PAL_DEPTH];
    video_pkg::layer_pxl_t       front;
    video_pkg::layer_pxl_t       back;
    video_pkg::layer_pxl_t       pick;
    logic [video_pkg::COL_W-1:0] colour;
    video_pkg::rgb_t             expanded;
    logic                        lhbl_d1;
    logic                        lvbl_d1;

    initial begin
        for (int i = 0; i < PAL_DEPTH; i++) begin
            pal_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pal_wr.en) begin
            pal_mem[pal_wr.index] <= pal_wr.colour;
        end
    end

    // Front layer wins unless transparent, backdrop at index 0
    always_comb begin
        front = prio ? pxl1 : pxl0;
        back  = prio ? pxl0 : pxl1;
        if (front.color != 4'd0) begin
            pick = front;
        end else if (back.color != 4'd0) begin
            pick = back;
        end else begin
            pick = '0;
        end
        colour = pal_mem[pick];
        // Nibble repeated equals c*17
        expanded.red   = {colour[11:8], colour[11:8]};
        expanded.green = {colour[7:4], colour[7:4]};
        expanded.blue  = {colour[3:0], colour[3:0]};
    end

    // Blanking delayed two pixels to line up with rgb
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            lhbl_d1  <= raster.lhbl;
            lvbl_d1  <= raster.lvbl;
            lhbl_dly <= lhbl_d1;
            lvbl_dly <= lvbl_d1;
            rgb      <= (lhbl_d1 && lvbl_d1) ? expanded : '0;
        end
    end

endmodule

// File: verilog/video_top.sv
// Tile video subsystem top
`timescale 1ns/1ps

module video_top #(
    parameter int H_TOTAL  = 64,
    parameter int H_ACTIVE = 48,
    parameter int V_TOTAL  = 40,
    parameter int V_ACTIVE = 32
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 cpu_valid,
    input  video_pkg::cpu_req_t  cpu_req,
    output logic                 cpu_ready,
    output logic                 hs,
    output logic                 vs,
    output logic                 lhbl,
    output logic                 lvbl,
    output logic                 lhbl_dly,
    output logic                 lvbl_dly,
    output video_pkg::rgb_t      rgb
);

    logic                   pxl_cen;
    video_pkg::raster_t     raster;
    video_pkg::map_wr_t     map0_wr;
    video_pkg::map_wr_t     map1_wr;
    video_pkg::pal_wr_t     pal_wr;
    video_pkg::scroll_t     scroll0;
    video_pkg::scroll_t     scroll1;
    logic                   prio;
    video_pkg::layer_pxl_t  pxl0;
    video_pkg::layer_pxl_t  pxl1;

    assign lhbl = raster.lhbl;
    assign lvbl = raster.lvbl;

    video_timing #(
        .H_TOTAL    ( H_TOTAL       ),
        .H_ACTIVE   ( H_ACTIVE      ),
        .V_TOTAL    ( V_TOTAL       ),
        .V_ACTIVE   ( V_ACTIVE      )
    ) u_timing (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .pxl_cen    ( pxl_cen       ),
        .raster     ( raster        ),
        .hs         ( hs            ),
        .vs         ( vs            )
    );

    cpu_reg_decode u_decode (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cpu_valid  ( cpu_valid     ),
        .cpu_req    ( cpu_req       ),
        .cpu_ready  ( cpu_ready     ),
        .raster     ( raster        ),
        .map0_wr    ( map0_wr       ),
        .map1_wr    ( map1_wr       ),
        .pal_wr     ( pal_wr        ),
        .scroll0    ( scroll0       ),
        .scroll1    ( scroll1       ),
        .prio       ( prio          )
    );

    tile_layer u_layer0 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .pxl_cen    ( pxl_cen       ),
        .raster     ( raster        ),
        .scroll     ( scroll0       ),
        .map_wr     ( map0_wr       ),
        .pxl        ( pxl0          )
    );

    tile_layer u_layer1 (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .pxl_cen    ( pxl_cen       ),
        .raster     ( raster        ),
        .scroll     ( scroll1       ),
        .map_wr     ( map1_wr       ),
        .pxl        ( pxl1          )
    );

    color_mixer u_mixer (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .pxl_cen    ( pxl_cen       ),
        .raster     ( raster        ),
        .pxl0       ( pxl0          ),
        .pxl1       ( pxl1          ),
        .prio       ( prio          ),
        .pal_wr     ( pal_wr        ),
        .rgb        ( rgb           ),
        .lhbl_dly   ( lhbl_dly      ),
        .lvbl_dly   ( lvbl_dly      )
    );

endmodule

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // Release just after an edge, like the rest of the stimulus
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        arst_n = 1'b1;
    end

endmodule

// File: testbench/video_assertions.sv
// CPU decoder handshake checks
`timescale 1ns/1ps

module video_assertions (
    input logic                clk,
    input logic                arst_n,
    input logic                cpu_valid,
    input video_pkg::cpu_req_t cpu_req,
    input logic                cpu_ready,
    input video_pkg::raster_t  raster,
    input video_pkg::map_wr_t  map0_wr,
    input video_pkg::map_wr_t  map1_wr,
    input video_pkg::pal_wr_t  pal_wr
);

    int   fail_count = 0;
    logic pal_req;
    logic strobe;

    assign pal_req = cpu_req.addr[11:8] == video_pkg::PAL_BASE[11:8];
    assign strobe  = map0_wr.en || map1_wr.en || pal_wr.en;

    // Requester holds the request while stalled
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_valid && !cpu_ready |=> $stable(cpu_req))
    else begin
        $error("cpu_req changed while stalled");
        fail_count++;
    end

    // A palette request made during active display never reaches the RAM
    pal_busy: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_valid && pal_req && raster.lhbl && raster.lvbl |=> !pal_wr.en)
    else begin
        $error("palette request accepted during active display");
        fail_count++;
    end

    strobe_accepted: assert property (@(posedge clk) disable iff (!arst_n)
        strobe |-> $past(cpu_valid && cpu_ready))
    else begin
        $error("write strobe without an accepted request");
        fail_count++;
    end

endmodule

bind cpu_reg_decode video_assertions u_assert (
    .clk       ( clk       ),
    .arst_n    ( arst_n    ),
    .cpu_valid ( cpu_valid ),
    .cpu_req   ( cpu_req   ),
    .cpu_ready ( cpu_ready ),
    .raster    ( raster    ),
    .map0_wr   ( map0_wr   ),
    .map1_wr   ( map1_wr   ),
    .pal_wr    ( pal_wr    )
);

// File: testbench/video_tb.sv
// Tile video subsystem testbench
`timescale 1ns/1ps

module video_tb;

    localparam int H_TOTAL   = 64;
    localparam int H_ACTIVE  = 48;
    localparam int V_TOTAL   = 40;
    localparam int V_ACTIVE  = 32;
    localparam int NUM_TESTS = 5;
    // Two clocks per pixel at 100 ns
    localparam longint FRAME_NS    = 64'(H_TOTAL * V_TOTAL * 2 * 100);
    localparam longint WATCHDOG_NS = (NUM_TESTS * 6 + 2) * FRAME_NS;

    logic                clk;
    logic                arst_n;
    logic                cpu_valid;
    video_pkg::cpu_req_t cpu_req;
    logic                cpu_ready;
    logic                hs;
    logic                vs;
    logic                lhbl;
    logic                lvbl;
    logic                lhbl_dly;
    logic                lvbl_dly;
    video_pkg::rgb_t     rgb;

    // Reference copy of everything the CPU has written
    logic [7:0]          map0_ref [64];
    logic [7:0]          map1_ref [64];
    logic [11:0]         pal_ref [256];
    video_pkg::scroll_t  scroll0_ref;
    video_pkg::scroll_t  scroll1_ref;
    logic                prio_ref;

    int   errors;
    int   checks;
    int   tests_run;
    int   test_start;
    int   assert_fails;
    logic check_en;
    int   pix_x;
    int   pix_y;
    int   pix_checked;
    logic prev_lhbl;
    logic cen_q;
    int   ras_h;
    int   ras_v;

    tb_clock_gen u_clock (
        .clk    ( clk    ),
        .arst_n ( arst_n )
    );

    video_top #(
        .H_TOTAL   ( H_TOTAL   ),
        .H_ACTIVE  ( H_ACTIVE  ),
        .V_TOTAL   ( V_TOTAL   ),
        .V_ACTIVE  ( V_ACTIVE  )
    ) i_dut (
        .clk       ( clk       ),
        .arst_n    ( arst_n    ),
        .cpu_valid ( cpu_valid ),
        .cpu_req   ( cpu_req   ),
        .cpu_ready ( cpu_ready ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .lhbl_dly  ( lhbl_dly  ),
        .lvbl_dly  ( lvbl_dly  ),
        .rgb       ( rgb       )
    );

    // Tile y times 8 plus tile x on the 64x64 plane
    function automatic logic [5:0] map_index(input int x, input int y,
                                             input video_pkg::scroll_t s);
        int px;
        int py;
        px = (x + int'(s.x)) % 64;
        py = (y + int'(s.y)) % 64;
        return 6'((py / 8) * 8 + px / 8);
    endfunction

    function automatic video_pkg::rgb_t expected_rgb(input int x, input int y);
        logic [7:0]      e0;
        logic [7:0]      e1;
        logic [7:0]      front;
        logic [7:0]      back;
        logic [7:0]      index;
        logic [11:0]     c;
        video_pkg::rgb_t exp_rgb;
        e0    = map0_ref[map_index(x, y, scroll0_ref)];
        e1    = map1_ref[map_index(x, y, scroll1_ref)];
        front = prio_ref ? e1 : e0;
        back  = prio_ref ? e0 : e1;
        if (front[3:0] != 4'd0) begin
            index = front;
        end else if (back[3:0] != 4'd0) begin
            index = back;
        end else begin
            index = 8'd0;
        end
        c = pal_ref[index];
        exp_rgb.red   = 8'(c[11:8] * 17);
        exp_rgb.green = 8'(c[7:4] * 17);
        exp_rgb.blue  = 8'(c[3:0] * 17);
        return exp_rgb;
    endfunction

    task automatic compare_rgb(input video_pkg::rgb_t got, input video_pkg::rgb_t exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s rgb %06h, expected %06h", $time, what, got, exp);
        end
    endtask

    task automatic compare_ready(input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: cpu_ready %0b, expected %0b", $time, got, exp);
        end
    endtask

    task automatic compare_sync(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s %0b, expected %0b", $time, what, got, exp);
        end
    endtask

    // Enable seen by the last rising edge, so the raster moved on that edge
    always @(posedge clk) begin
        cen_q <= i_dut.pxl_cen;
    end

    // Raster model from the reset position, one step per pixel
    always @(negedge clk) begin
        if (!arst_n) begin
            ras_h = H_TOTAL - 1;
            ras_v = V_TOTAL - 1;
        end else if (cen_q) begin
            if (ras_h == H_TOTAL - 1) begin
                ras_h = 0;
                ras_v = (ras_v + 1) % V_TOTAL;
            end else begin
                ras_h++;
            end
            compare_sync(lhbl, ras_h < H_ACTIVE, "lhbl");
            compare_sync(lvbl, ras_v < V_ACTIVE, "lvbl");
            compare_sync(hs, ras_h >= H_ACTIVE + 4 && ras_h < H_ACTIVE + 8, "hs");
            compare_sync(vs, ras_v >= V_ACTIVE + 4 && ras_v < V_ACTIVE + 8, "vs");
        end
    end

    // Pixel monitor, one sample per pixel after the enable edge
    always @(negedge clk) begin
        if (arst_n && !i_dut.pxl_cen) begin
            if (!lhbl_dly || !lvbl_dly) begin
                compare_rgb(rgb, '0, "blank");
            end else if (check_en) begin
                compare_rgb(rgb, expected_rgb(pix_x, pix_y),
                            $sformatf("pixel %0d,%0d", pix_x, pix_y));
                pix_checked++;
            end
            if (!lvbl_dly) begin
                pix_x = 0;
                pix_y = 0;
            end else if (lhbl_dly) begin
                pix_x++;
            end else if (prev_lhbl) begin
                pix_x = 0;
                pix_y++;
            end
            prev_lhbl = lhbl_dly;
        end
    end

    task automatic cpu_write(input logic [11:0] addr, input logic [15:0] data,
                             output int waits);
        logic is_pal;
        logic done;
        is_pal = addr[11:8] == video_pkg::PAL_BASE[11:8];
        waits  = 0;
        done   = 1'b0;
        @(posedge clk);
        #10;
        cpu_valid    = 1'b1;
        cpu_req.addr = addr;
        cpu_req.data = data;
        while (!done) begin
            @(negedge clk);
            compare_ready(cpu_ready, !(is_pal && lhbl && lvbl));
            if (cpu_ready) begin
                done = 1'b1;
            end else begin
                waits++;
            end
        end
        @(posedge clk);
        #10;
        cpu_valid = 1'b0;
    endtask

    task automatic write_map(input int layer, input logic [5:0] idx, input logic [7:0] entry,
                             output int waits);
        if (layer == 0) begin
            cpu_write(video_pkg::MAP0_BASE + 12'(idx), {8'h00, entry}, waits);
            map0_ref[idx] = entry;
        end else begin
            cpu_write(video_pkg::MAP1_BASE + 12'(idx), {8'h00, entry}, waits);
            map1_ref[idx] = entry;
        end
    endtask

    task automatic write_pal(input logic [7:0] idx, input logic [11:0] colour,
                             output int waits);
        cpu_write(video_pkg::PAL_BASE + 12'(idx), {4'h0, colour}, waits);
        pal_ref[idx] = colour;
    endtask

    task automatic write_scroll(input int layer, input logic [5:0] x, input logic [5:0] y);
        int waits;
        cpu_write(video_pkg::SCROLL_BASE + 12'(2 * layer), {10'h000, x}, waits);
        cpu_write(video_pkg::SCROLL_BASE + 12'(2 * layer + 1), {10'h000, y}, waits);
        if (layer == 0) begin
            scroll0_ref = {x, y};
        end else begin
            scroll1_ref = {x, y};
        end
    endtask

    task automatic write_prio(input logic p);
        int waits;
        cpu_write(video_pkg::PRIO_ADDR, {15'h0000, p}, waits);
        prio_ref = p;
    endtask

    // Check a whole frame whose lookups all start after the last write
    task automatic check_frame();
        @(negedge lvbl);
        @(posedge lvbl_dly);
        pix_checked = 0;
        check_en    = 1'b1;
        @(negedge lvbl_dly);
        check_en = 1'b0;
        if (pix_checked != H_ACTIVE * V_ACTIVE) begin
            errors++;
            $display("frame showed %0d active pixels instead of %0d",
                     pix_checked, H_ACTIVE * V_ACTIVE);
        end
    endtask

    task automatic wait_active_line();
        logic found;
        found = 1'b0;
        while (!found) begin
            @(posedge lhbl);
            @(negedge clk);
            found = lvbl;
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, errors - test_start);
        test_start = errors;
        tests_run++;
    endtask

    task automatic test_reset_blank();
        check_frame();
        finish_test("reset and blank");
    endtask

    task automatic test_layer0();
        int waits;
        for (int i = 0; i < 256; i++) begin
            write_pal(8'(i), 12'($urandom), waits);
        end
        for (int i = 0; i < 64; i++) begin
            write_map(0, 6'(i), 8'($urandom), waits);
        end
        check_frame();
        finish_test("layer 0 display");
    endtask

    task automatic test_scroll();
        int waits;
        for (int i = 0; i < 64; i++) begin
            write_map(1, 6'(i), 8'($urandom), waits);
        end
        // Offsets of 32 or more force a wrap inside the frame
        write_scroll(0, 6'(32 + $urandom % 32), 6'(32 + $urandom % 32));
        write_scroll(1, 6'(32 + $urandom % 32), 6'($urandom));
        check_frame();
        finish_test("scroll");
    endtask

    task automatic test_priority();
        int         waits;
        logic [7:0] entry;
        for (int i = 0; i < 128; i++) begin
            entry = 8'($urandom);
            if ($urandom % 2 == 0) begin
                entry[3:0] = 4'h0;
            end
            write_map(i / 64, 6'(i % 64), entry, waits);
        end
        write_prio(1'b0);
        check_frame();
        write_prio(1'b1);
        check_frame();
        finish_test("priority");
    endtask

    task automatic test_backpressure();
        int waits;
        write_prio(1'b0);
        wait_active_line();
        // Opaque layer 0 everywhere, so palette entry 1F fills the screen
        for (int i = 0; i < 64; i++) begin
            write_map(0, 6'(i), 8'h1f, waits);
            if (waits != 0) begin
                errors++;
                $display("map write %0d was stalled for %0d cycles", i, waits);
            end
        end
        wait_active_line();
        write_pal(8'h1f, ~pal_ref[8'h1f], waits);
        if (waits == 0) begin
            errors++;
            $display("palette write was accepted during active display");
        end
        check_frame();
        finish_test("palette back-pressure");
    endtask

    initial begin
        void'($urandom(32'he00c_b317));
        cpu_valid   = 1'b0;
        cpu_req     = '0;
        errors      = 0;
        checks      = 0;
        tests_run   = 0;
        test_start  = 0;
        check_en    = 1'b0;
        pix_x       = 0;
        pix_y       = 0;
        pix_checked = 0;
        prev_lhbl   = 1'b0;
        scroll0_ref = '0;
        scroll1_ref = '0;
        prio_ref    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            map0_ref[i] = 8'h00;
            map1_ref[i] = 8'h00;
        end
        for (int i = 0; i < 256; i++) begin
            pal_ref[i] = 12'h000;
        end
        @(posedge arst_n);
        test_reset_blank();
        test_layer0();
        test_scroll();
        test_priority();
        test_backpressure();
        assert_fails = i_dut.u_decode.u_assert.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 tests_run, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: list.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/cpu_reg_decode.sv
verilog/tile_layer.sv
verilog/color_mixer.sv
verilog/video_top.sv
testbench/tb_clock_gen.sv
testbench/video_assertions.sv
testbench/video_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= video_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
